// ==== sources.f ====
+incdir+common
common/axis_stream_pkg.sv
common/axis_route_pkg.sv
src/axis_route_select.sv
demux/axis_if_demux.sv
fifo/axis_chan_fifo.sv
arbiter/axis_packet_arbiter.sv
src/axis_stream_router.sv
sim/axis_stream_router_assert.sv
sim/axis_stream_router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the router testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module axis_stream_router_tb \
    -o router_sim

if ! ./obj_dir/router_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

// ==== sim/axis_stream_router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_router_defs.svh"

module axis_stream_router_tb;

    localparam int NUM_TESTS   = 12;
    localparam int MODE_ALWAYS = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_HOLD   = 2;     // m_tready low until the group is sent

    logic                       aclk;
    logic                       reset;
    logic                       s_tvalid;
    logic                       s_tready;
    logic [`AXR_DATA_WIDTH-1:0] s_tdata;
    logic                       s_tlast;
    logic                       m_tvalid;
    logic                       m_tready;
    logic [`AXR_DATA_WIDTH-1:0] m_tdata;
    logic                       m_tlast;
    axis_route_pkg::chan_t      m_tid;

    // Stimulus table, one packet per row
    string       t_name [NUM_TESTS];
    int          t_chan [NUM_TESTS];
    int          t_len  [NUM_TESTS];
    logic [15:0] t_tag  [NUM_TESTS];
    int          t_mode [NUM_TESTS];
    int          rows;

    logic [`AXR_DATA_WIDTH:0] exp_q [`AXR_CHANNELS][$];    // {tlast, tdata}
    int pkt_order [$];          // m_tid of each finished packet
    int ready_mode;
    int last_tid;
    int pkt_tid;
    bit in_pkt;
    int err_count;
    int cycle_count = 0;
    int cycle_limit;

    axis_stream_router UUT (.*);

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            err_count++;
        end
    endtask

    task automatic add_row(input string name, input int chan, input int len,
                           input logic [15:0] tag, input int mode);
        t_name[rows] = name;
        t_chan[rows] = chan;
        t_len[rows]  = len;
        t_tag[rows]  = tag;
        t_mode[rows] = mode;
        rows++;
    endtask

    function automatic int queued_beats();
        int n;
        n = 0;
        for (int i = 0; i < `AXR_CHANNELS; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    // Starts and ends on a falling edge
    task automatic send_beat(input logic [31:0] data, input logic last);
        s_tvalid = 1'b1;
        s_tdata  = data;
        s_tlast  = last;
        @(posedge aclk);
        while (!s_tready) begin
            @(posedge aclk);
        end
        @(negedge aclk);
    endtask

    task automatic send_packet(input int row);
        axis_stream_pkg::beat_u hdr;
        logic [31:0]            word;
        hdr.raw         = '0;
        hdr.hdr.channel = 2'(t_chan[row]);
        hdr.hdr.length  = 8'(t_len[row]);
        hdr.hdr.tag     = t_tag[row];
        exp_q[t_chan[row]].push_back({1'b0, hdr.raw});
        send_beat(hdr.raw, 1'b0);
        for (int i = 1; i <= t_len[row]; i++) begin
            word = $urandom;
            exp_q[t_chan[row]].push_back({i == t_len[row], word});
            send_beat(word, i == t_len[row]);
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    initial begin
        m_tready = 1'b0;
        forever begin
            @(negedge aclk);
            case (ready_mode)
                MODE_RANDOM: m_tready = 1'($urandom_range(0, 1));
                MODE_HOLD:   m_tready = 1'b0;
                default:     m_tready = 1'b1;
            endcase
        end
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("ERROR: run timed out after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(posedge aclk) begin : monitor
        axis_stream_pkg::beat_u   hdr;
        logic [`AXR_DATA_WIDTH:0] want;
        if (!reset && m_tvalid && m_tready) begin
            if (exp_q[m_tid].size() == 0) begin
                $display("ERROR: unexpected beat on channel %0d", m_tid);
                err_count++;
            end else begin
                want = exp_q[m_tid].pop_front();
                check_value("m_tdata", m_tdata, want[`AXR_DATA_WIDTH-1:0]);
                check_value("m_tlast", 32'(m_tlast), 32'(want[`AXR_DATA_WIDTH]));
                hdr.raw = want[`AXR_DATA_WIDTH-1:0];
                if (!in_pkt) begin
                    pkt_tid = int'(hdr.hdr.channel);    // Header opens the packet
                end
                check_value("m_tid", 32'(m_tid), 32'(pkt_tid));
                in_pkt   = !m_tlast;
                last_tid = int'(m_tid);
                if (m_tlast) begin
                    pkt_order.push_back(int'(m_tid));
                end
            end
        end
    end

    initial begin
        int first;
        int group_err;
        int start_tid;
        int beats;
        int tests_failed;
        void'($urandom(32'haeb5bcb4));
        rows         = 0;
        err_count    = 0;
        in_pkt       = 1'b0;
        last_tid     = `AXR_CHANNELS - 1;   // First grant search starts at 0
        ready_mode   = MODE_ALWAYS;
        tests_failed = 0;
        reset        = 1'b1;
        s_tvalid     = 1'b0;
        s_tdata      = '0;
        s_tlast      = 1'b0;

        add_row("short_ch0", 0, 1, 16'h0a01, MODE_ALWAYS);
        add_row("route_ch1", 1, 4, 16'h0a02, MODE_ALWAYS);
        add_row("route_ch2", 2, 7, 16'h0a03, MODE_ALWAYS);
        add_row("route_ch3", 3, 12, 16'h0a04, MODE_ALWAYS);
        add_row("bp_ch2_a", 2, 3, 16'h0b01, MODE_RANDOM);
        add_row("bp_ch2_b", 2, 9, 16'h0b02, MODE_RANDOM);
        add_row("bp_ch0", 0, 12, 16'h0b03, MODE_RANDOM);
        add_row("lead_ch1", 1, 5, 16'h0c01, MODE_ALWAYS);
        add_row("rr_ch2", 2, 12, 16'h0d01, MODE_HOLD);
        add_row("rr_ch0", 0, 10, 16'h0d02, MODE_HOLD);
        add_row("rr_ch3", 3, 8, 16'h0d03, MODE_HOLD);
        add_row("rr_ch1", 1, 11, 16'h0d04, MODE_HOLD);

        beats = 0;
        for (int r = 0; r < NUM_TESTS; r++) begin
            beats += t_len[r] + 1;
        end
        cycle_limit = 8 * beats + 2000;

        repeat (8) @(negedge aclk);
        reset = 1'b0;
        @(negedge aclk);
        check_value("m_tvalid", 32'(m_tvalid), 32'h0);
        check_value("s_tready", 32'(s_tready), 32'h1);

        first     = 0;
        group_err = err_count;
        start_tid = last_tid;
        for (int r = 0; r < NUM_TESTS; r++) begin
            if (r == first) begin
                group_err  = err_count;
                start_tid  = last_tid;
                ready_mode = t_mode[r];
                pkt_order.delete();
            end
            send_packet(r);
            if (r == NUM_TESTS - 1 || t_mode[r + 1] != t_mode[r]) begin
                if (t_mode[r] == MODE_HOLD) begin
                    ready_mode = MODE_ALWAYS;   // Release the held output
                end
                while (queued_beats() != 0) begin
                    @(negedge aclk);
                end
                if (t_mode[r] == MODE_HOLD) begin
                    check_value("packet count", pkt_order.size(), r - first + 1);
                    foreach (pkt_order[k]) begin
                        check_value("m_tid", pkt_order[k], (start_tid + 1 + k) % `AXR_CHANNELS);
                    end
                end
                for (int i = first; i <= r; i++) begin
                    $display("%s: %s", t_name[i],
                             (err_count == group_err) ? "passed" : "failed");
                    if (err_count != group_err) begin
                        tests_failed++;
                    end
                end
                first = r + 1;
            end
        end

        repeat (20) @(negedge aclk);    // Stray beats show up here
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 NUM_TESTS - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/axis_stream_router_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_router_defs.svh"

module axis_stream_router_assert (
    input logic                        aclk,
    input logic                        reset,
    input logic                        s_tvalid,
    input logic                        m_tvalid,
    input logic                        m_tready,
    input logic [`AXR_DATA_WIDTH-1:0]  m_tdata,
    input logic                        m_tlast,
    input axis_route_pkg::chan_t       m_tid,
    input axis_route_pkg::arb_state_t  arb_state
);

    // Stalled beat must not move
    m_stall_stable: assert property (@(posedge aclk) disable iff (reset)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
                                  && $stable(m_tid))
        else $error("output beat changed while m_tready was low");

    s_idle_in_reset: assert property (@(posedge aclk) reset |-> !s_tvalid)
        else $error("s_tvalid high during reset");

    // Output quiet and arbiter choosing right after reset
    m_idle_after_reset: assert property (@(posedge aclk) $fell(reset) |->
        !m_tvalid && arb_state == axis_route_pkg::ARB_IDLE)
        else $error("output or arbiter not idle right after reset");

endmodule

bind axis_stream_router axis_stream_router_assert u_assert (
    .aclk      (aclk),
    .reset     (reset),
    .s_tvalid  (s_tvalid),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tdata   (m_tdata),
    .m_tlast   (m_tlast),
    .m_tid     (m_tid),
    .arb_state (u_arbiter.state)
);

`default_nettype wire

// ==== src/axis_stream_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_router_defs.svh"

module axis_stream_router (
    input  logic                        aclk,
    input  logic                        reset,

    input  logic                        s_tvalid,
    output logic                        s_tready,
    input  logic [`AXR_DATA_WIDTH-1:0]  s_tdata,
    input  logic                        s_tlast,

    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic [`AXR_DATA_WIDTH-1:0]  m_tdata,
    output logic                        m_tlast,
    output axis_route_pkg::chan_t       m_tid
);

    axis_route_pkg::chan_t sel;

    // Demux side of the FIFOs
    logic [`AXR_CHANNELS-1:0]   ch_in_tvalid;
    logic [`AXR_CHANNELS-1:0]   ch_in_tready;
    logic [`AXR_DATA_WIDTH-1:0] ch_in_tdata [`AXR_CHANNELS];
    logic [`AXR_CHANNELS-1:0]   ch_in_tlast;

    // Arbiter side of the FIFOs
    logic [`AXR_CHANNELS-1:0]   ch_out_tvalid;
    logic [`AXR_CHANNELS-1:0]   ch_out_tready;
    logic [`AXR_DATA_WIDTH-1:0] ch_out_tdata [`AXR_CHANNELS];
    logic [`AXR_CHANNELS-1:0]   ch_out_tlast;

    axis_route_select u_route_select (
        .aclk     (aclk),
        .reset    (reset),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tlast  (s_tlast),
        .sel      (sel)
    );

    axis_if_demux #(
        .CHANNEL_NUMBER (`AXR_CHANNELS)
    ) u_demux (
        .in_tvalid  (s_tvalid),
        .in_tready  (s_tready),
        .in_tdata   (s_tdata),
        .in_tlast   (s_tlast),
        .sel        (sel),
        .out_tvalid (ch_in_tvalid),
        .out_tready (ch_in_tready),
        .out_tdata  (ch_in_tdata),
        .out_tlast  (ch_in_tlast)
    );

    for (genvar i = 0; i < `AXR_CHANNELS; i++) begin : gen_fifo
        axis_chan_fifo #(
            .DEPTH (`AXR_FIFO_DEPTH)
        ) u_fifo (
            .aclk     (aclk),
            .reset    (reset),
            .s_tvalid (ch_in_tvalid[i]),
            .s_tready (ch_in_tready[i]),
            .s_tdata  (ch_in_tdata[i]),
            .s_tlast  (ch_in_tlast[i]),
            .m_tvalid (ch_out_tvalid[i]),
            .m_tready (ch_out_tready[i]),
            .m_tdata  (ch_out_tdata[i]),
            .m_tlast  (ch_out_tlast[i])
        );
    end

    axis_packet_arbiter #(
        .CHANNEL_NUMBER (`AXR_CHANNELS)
    ) u_arbiter (
        .aclk      (aclk),
        .reset     (reset),
        .in_tvalid (ch_out_tvalid),
        .in_tready (ch_out_tready),
        .in_tdata  (ch_out_tdata),
        .in_tlast  (ch_out_tlast),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .m_tdata   (m_tdata),
        .m_tlast   (m_tlast),
        .m_tid     (m_tid)
    );

endmodule

`default_nettype wire

// ==== arbiter/axis_packet_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_router_defs.svh"

module axis_packet_arbiter #(
    parameter int CHANNEL_NUMBER = `AXR_CHANNELS
) (
    input  logic                        aclk,
    input  logic                        reset,

    input  logic [CHANNEL_NUMBER-1:0]   in_tvalid,
    output logic [CHANNEL_NUMBER-1:0]   in_tready,
    input  logic [`AXR_DATA_WIDTH-1:0]  in_tdata [CHANNEL_NUMBER],
    input  logic [CHANNEL_NUMBER-1:0]   in_tlast,

    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic [`AXR_DATA_WIDTH-1:0]  m_tdata,
    output logic                        m_tlast,
    output axis_route_pkg::chan_t       m_tid
);

    axis_route_pkg::arb_state_t state;
    axis_route_pkg::chan_t      grant;      // Also the round-robin pointer
    axis_route_pkg::chan_t      pick;
    logic                       pick_valid;
    logic                       locked;

    assign locked = (state == axis_route_pkg::ARB_LOCKED);

    // First requester after the last grant
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick       = grant;
        for (int i = 1; i <= CHANNEL_NUMBER; i++) begin
            idx = (int'(grant) + i) % CHANNEL_NUMBER;
            if (!pick_valid && in_tvalid[idx]) begin
                pick_valid = 1'b1;
                pick       = axis_route_pkg::chan_t'(idx);
            end
        end
    end

    always_comb begin
        in_tready        = '0;
        in_tready[grant] = locked && m_tready;
    end

    assign m_tvalid = locked && in_tvalid[grant];
    assign m_tdata  = in_tdata[grant];
    assign m_tlast  = in_tlast[grant];
    assign m_tid    = grant;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= axis_route_pkg::ARB_IDLE;
            grant <= axis_route_pkg::chan_t'(CHANNEL_NUMBER - 1);  // First search hits 0
        end else begin
            case (state)
                axis_route_pkg::ARB_IDLE: begin
                    if (pick_valid) begin
                        grant <= pick;
                        state <= axis_route_pkg::ARB_LOCKED;
                    end
                end
                axis_route_pkg::ARB_LOCKED: begin
                    if (m_tvalid && m_tready && m_tlast) begin
                        state <= axis_route_pkg::ARB_IDLE;   // Packet done
                    end
                end
                default: state <= axis_route_pkg::ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== fifo/axis_chan_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_router_defs.svh"

module axis_chan_fifo #(
    parameter int DEPTH = `AXR_FIFO_DEPTH
) (
    input  logic                        aclk,
    input  logic                        reset,

    input  logic                        s_tvalid,
    output logic                        s_tready,
    input  logic [`AXR_DATA_WIDTH-1:0]  s_tdata,
    input  logic                        s_tlast,

    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic [`AXR_DATA_WIDTH-1:0]  m_tdata,
    output logic                        m_tlast
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`AXR_DATA_WIDTH:0] mem [DEPTH];     // tlast in the top bit
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;
    logic                     full;
    logic                     wr_en;
    logic                     rd_en;

    assign full     = (count == CNT_W'(DEPTH));
    assign m_tvalid = (count != '0);
    assign rd_en    = m_tvalid && m_tready;
    assign s_tready = !full || m_tready;      // Full but draining this cycle
    assign wr_en    = s_tvalid && s_tready;

    // Head word straight from the store
    assign {m_tlast, m_tdata} = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {s_tlast, s_tdata};
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== demux/axis_if_demux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_router_defs.svh"

module axis_if_demux #(
    parameter int CHANNEL_NUMBER = `AXR_CHANNELS
) (
    input  logic                        in_tvalid,
    output logic                        in_tready,
    input  logic [`AXR_DATA_WIDTH-1:0]  in_tdata,
    input  logic                        in_tlast,

    input  axis_route_pkg::chan_t       sel,

    output logic [CHANNEL_NUMBER-1:0]   out_tvalid,
    input  logic [CHANNEL_NUMBER-1:0]   out_tready,
    output logic [`AXR_DATA_WIDTH-1:0]  out_tdata [CHANNEL_NUMBER],
    output logic [CHANNEL_NUMBER-1:0]   out_tlast
);

    always_comb begin
        in_tready = out_tready[sel];

        // Idle channels see an all-zero bus
        for (int i = 0; i < CHANNEL_NUMBER; i++) begin
            out_tvalid[i] = 1'b0;
            out_tdata[i]  = '0;
            out_tlast[i]  = 1'b0;
        end

        out_tvalid[sel] = in_tvalid;
        out_tdata[sel]  = in_tdata;
        out_tlast[sel]  = in_tlast;
    end

endmodule

`default_nettype wire

// ==== src/axis_route_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_router_defs.svh"

module axis_route_select (
    input  logic                        aclk,
    input  logic                        reset,
    input  logic                        s_tvalid,
    input  logic                        s_tready,
    input  logic [`AXR_DATA_WIDTH-1:0]  s_tdata,
    input  logic                        s_tlast,
    output axis_route_pkg::chan_t       sel
);

    axis_stream_pkg::beat_u beat;
    axis_route_pkg::chan_t  chan_q;     // Channel of the open packet
    logic                   pkt_open;
    logic                   accept;

    assign beat.raw = s_tdata;
    assign accept   = s_tvalid && s_tready;

    // Header beat routes itself, later beats follow the latch
    assign sel = pkt_open ? chan_q : beat.hdr.channel;

    always_ff @(posedge aclk) begin
        if (reset) begin
            pkt_open <= 1'b0;
        end else if (accept) begin
            if (s_tlast) begin
                pkt_open <= 1'b0;       // Single-beat packet closes at once
            end else if (!pkt_open) begin
                pkt_open <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && !pkt_open) begin
            chan_q <= beat.hdr.channel;
        end
    end

endmodule

`default_nettype wire

// ==== common/axis_route_pkg.sv ====
`default_nettype none

`include "axis_router_defs.svh"

package axis_route_pkg;

    typedef logic [$clog2(`AXR_CHANNELS)-1:0] chan_t;

    typedef enum logic {
        ARB_IDLE   = 1'b0,  // Choosing the next grant
        ARB_LOCKED = 1'b1   // Passing one packet through
    } arb_state_t;

endpackage

`default_nettype wire

// ==== common/axis_stream_pkg.sv ====
`default_nettype none

`include "axis_router_defs.svh"

package axis_stream_pkg;

    // First beat of every packet
    typedef struct packed {
        logic [15:0] tag;       // Carried through, not checked
        logic [7:0]  length;    // Payload beats after the header
        logic [5:0]  reserved;
        logic [1:0]  channel;   // Output channel select
    } header_t;

    // One tdata word seen as a header or as plain payload
    typedef union packed {
        header_t                    hdr;
        logic [`AXR_DATA_WIDTH-1:0] raw;
    } beat_u;

endpackage

`default_nettype wire

// ==== common/axis_router_defs.svh ====
`ifndef AXIS_ROUTER_DEFS_SVH
`define AXIS_ROUTER_DEFS_SVH

// Number of output channels behind the demux
`define AXR_CHANNELS 4

// Stream word width, also the header word width
`define AXR_DATA_WIDTH 32

// Entries per channel FIFO
`define AXR_FIFO_DEPTH 16

`endif
